/* vlog.f */
logic/dcache_geom_pkg.sv
logic/dcache_port_pkg.sv
logic/dcache_ctrl.sv
logic/dcache_tag_array.sv
logic/dcache_lru.sv
logic/dcache_data_array.sv
logic/dcache_burst_seq.sv
logic/dcache_top.sv
testbench/dcache_asserts.sv
testbench/tb_dcache.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dcache
FILELIST = vlog.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;

  localparam int mem_words = 4096;
  localparam int num_tests = 6;

  logic                      clk, rst, req, ok, miss, rdata_ok, wdata_ok;
  logic [31:0]               rdata, sdata;
  dcache_port_pkg::cpu_req_t cpu_in;
  dcache_port_pkg::mem_rd_t  mem_rd;
  dcache_port_pkg::mem_wr_t  mem_wr;

  logic [31:0] mem    [mem_words];   // Memory behind the bus
  logic [31:0] shadow [mem_words];   // Contents as the CPU should see them
  logic [31:0] seed = 32'h42e34fb5;
  logic [31:0] lcg_val, last_raddr, last_waddr;
  logic [3:0]  rd_ptr, wr_ptr;
  logic        rd_active, wr_active;
  logic        sen_q, wen_q;
  logic [31:0] wdata_q;
  logic [31:0] wb_words [$];
  int          served, sen_bursts, errors, tests_run;

  dcache_top i_dcache_top (.clk, .rst, .req, .cpu_in, .rdata, .ok, .miss, .mem_rd,
    .rdata_ok, .sdata, .mem_wr, .wdata_ok);

  bind dcache_top dcache_asserts i_dcache_asserts (.clk, .rst, .state, .ok, .miss,
    .sen, .wen, .burst_done);

  always #10 clk = ~clk;

  function logic [31:0] rand_word();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function logic [31:0] line_addr(input logic [21:0] tag, input logic [3:0] set,
                                  input logic [3:0] word);
    return {tag, set, word, 2'b00};
  endfunction

  task mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  // Bus as it stands before the next edge
  always @(negedge clk)
  begin
    sen_q   = mem_rd.sen;
    wen_q   = mem_wr.wen;
    wdata_q = mem_wr.wdata;
  end

  always @(posedge clk)
  begin
    if (sen_q && rdata_ok)
    begin
      rd_ptr = rd_ptr + 4'd1;   // Wraps inside the line
      served++;
    end
    if (wen_q && wdata_ok)
    begin
      mem[{last_waddr[13:6], wr_ptr}] = wdata_q;
      wb_words.push_back(wdata_q);
      wr_ptr = wr_ptr + 4'd1;
    end
    #2;
    if (mem_rd.sen && !rd_active)
    begin
      rd_active  = 1'b1;
      last_raddr = mem_rd.raddr;
      rd_ptr     = mem_rd.raddr[5:2];   // First word is the requested one
      served     = 0;
      sen_bursts++;
    end
    else if (!mem_rd.sen && rd_active)
    begin
      rd_active = 1'b0;
      if (served != 16)
      begin
        $display("Refill burst served %0d words instead of 16", served);
        errors++;
      end
    end
    if (mem_wr.wen && !wr_active)
    begin
      wr_active  = 1'b1;
      last_waddr = mem_wr.waddr;
      wr_ptr     = 4'd0;
      wb_words.delete();
    end
    else if (!mem_wr.wen && wr_active)
      wr_active = 1'b0;
    lcg_val  = rand_word();
    rdata_ok = mem_rd.sen && (lcg_val[5:4] != 2'b00);   // Random back-pressure
    wdata_ok = mem_wr.wen && (lcg_val[9:8] != 2'b00);
    sdata    = mem[{last_raddr[13:6], rd_ptr}];
  end

  task automatic cpu_access(input logic [31:0] addr, input logic we, input logic [3:0] wbyte,
                            input logic [31:0] wdata, output logic [31:0] rd,
                            output logic saw_miss);
    int cycles;
    cycles   = 0;
    saw_miss = 1'b0;
    @(posedge clk);
    #2;
    req          = 1'b1;
    cpu_in.addr  = addr;
    cpu_in.wdata = wdata;
    cpu_in.wbyte = wbyte;
    cpu_in.we    = we;
    @(negedge clk);
    while (!ok && cycles < 200)
    begin
      saw_miss |= miss;
      cycles++;
      @(negedge clk);
    end
    if (!ok)
    begin
      $display("No ok from the DUT within 200 cycles for address %h", addr);
      errors++;
    end
    rd = rdata;
    @(posedge clk);
    #2;
    req = 1'b0;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic exp_miss);
    logic [31:0] rd;
    logic        m;
    cpu_access(addr, 1'b0, 4'h0, 32'h0, rd, m);
    if (rd !== shadow[addr[13:2]])
      mismatch($sformatf("read %h gave %h, expected %h", addr, rd, shadow[addr[13:2]]));
    if (m !== exp_miss)
      mismatch($sformatf("read %h miss %b, expected %b", addr, m, exp_miss));
  endtask

  task automatic write_check(input logic [31:0] addr, input logic [3:0] wbyte,
                             input logic [31:0] wdata, input logic exp_miss);
    logic [31:0] rd;
    logic        m;
    cpu_access(addr, 1'b1, wbyte, wdata, rd, m);
    for (int b = 0; b < 4; b++)
      if (wbyte[b])
        shadow[addr[13:2]][8*b +: 8] = wdata[8*b +: 8];
    if (m !== exp_miss)
      mismatch($sformatf("write %h miss %b, expected %b", addr, m, exp_miss));
  endtask

  task finish_test(input string name);
    tests_run++;
    $display("Test %0d %s finished, %0d errors so far", tests_run, name, errors);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task reset_values();
    @(negedge clk);
    if (ok !== 1'b0 || miss !== 1'b0 || mem_rd.sen !== 1'b0 || mem_wr.wen !== 1'b0)
      mismatch("ok, miss, sen or wen not low after reset");
    finish_test("reset");
  endtask

  task read_miss_then_hit();
    int bursts;
    read_check(line_addr(22'd1, 4'd3, 4'd5), 1'b1);
    if (last_raddr !== line_addr(22'd1, 4'd3, 4'd5))
      mismatch($sformatf("raddr %h, expected %h", last_raddr, line_addr(22'd1, 4'd3, 4'd5)));
    bursts = sen_bursts;
    read_check(line_addr(22'd1, 4'd3, 4'd5), 1'b0);
    if (sen_bursts != bursts)
      mismatch("repeated read started a refill");
    finish_test("read_miss");
  endtask

  task write_hit_merge();
    write_check(line_addr(22'd1, 4'd3, 4'd9), 4'b0101, 32'ha5a5_5a5a, 1'b0);
    read_check(line_addr(22'd1, 4'd3, 4'd9), 1'b0);
    finish_test("write_hit");
  endtask

  task dirty_evict();
    logic [31:0] base;
    base = line_addr(22'd1, 4'd7, 4'd0);
    read_check(base, 1'b1);
    write_check(line_addr(22'd1, 4'd7, 4'd3), 4'hf, 32'h1234_5678, 1'b0);
    for (int t = 2; t <= 4; t++)
      read_check(line_addr(t[21:0], 4'd7, 4'd0), 1'b1);
    // Ages now 3,2,1,0 so way 0 with the dirty line goes
    read_check(line_addr(22'd5, 4'd7, 4'd2), 1'b1);
    if (last_waddr !== base)
      mismatch($sformatf("waddr %h, expected %h", last_waddr, base));
    if (wb_words.size() != 16)
      mismatch($sformatf("write-back carried %0d words", wb_words.size()));
    else
      for (int i = 0; i < 16; i++)
        if (wb_words[i] !== shadow[{base[13:6], i[3:0]}])
          mismatch($sformatf("write-back word %0d is %h, expected %h", i, wb_words[i],
                             shadow[{base[13:6], i[3:0]}]));
    finish_test("evict");
  endtask

  task age_victim();
    int bursts;
    for (int t = 1; t <= 4; t++)
      read_check(line_addr(t[21:0], 4'd9, 4'd1), 1'b1);
    read_check(line_addr(22'd1, 4'd9, 4'd1), 1'b0);   // Ages 0,3,2,1
    read_check(line_addr(22'd5, 4'd9, 4'd1), 1'b1);
    bursts = sen_bursts;
    read_check(line_addr(22'd1, 4'd9, 4'd1), 1'b0);
    read_check(line_addr(22'd3, 4'd9, 4'd1), 1'b0);
    read_check(line_addr(22'd4, 4'd9, 4'd1), 1'b0);
    if (sen_bursts != bursts)
      mismatch("read of a kept line started a refill");
    read_check(line_addr(22'd2, 4'd9, 4'd1), 1'b1);   // Second line was the victim
    if (sen_bursts != bursts + 1)
      mismatch("second-loaded line was not refilled again");
    finish_test("age_victim");
  endtask

  task write_miss_alloc();
    write_check(line_addr(22'd6, 4'd2, 4'd11), 4'b1100, 32'hdead_beef, 1'b1);
    read_check(line_addr(22'd6, 4'd2, 4'd11), 1'b0);
    finish_test("write_miss");
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = 1'b0;
    cpu_in     = '0;
    rdata_ok   = 1'b0;
    wdata_ok   = 1'b0;
    sdata      = '0;
    rd_active  = 1'b0;
    wr_active  = 1'b0;
    sen_q      = 1'b0;
    wen_q      = 1'b0;
    wdata_q    = '0;
    rd_ptr     = '0;
    wr_ptr     = '0;
    last_raddr = '0;
    last_waddr = '0;
    errors     = 0;
    tests_run  = 0;
    sen_bursts = 0;
    served     = 0;
    for (int i = 0; i < mem_words; i++)
    begin
      mem[i]    = rand_word();
      shadow[i] = mem[i];
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_values();
    read_miss_then_hit();
    write_hit_merge();
    dirty_evict();
    age_victim();
    write_miss_alloc();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog, 400 cycles per test
  initial
  begin
    #(num_tests * 400 * 20);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* testbench/dcache_asserts.sv */
`timescale 1ns/1ns

module dcache_asserts (
  input logic                         clk,
  input logic                         rst,
  input dcache_port_pkg::ctrl_state_t state,
  input logic                         ok,
  input logic                         miss,
  input logic                         sen,
  input logic                         wen,
  input logic                         burst_done
);

  ////////////////////////////////////////
  // Controller properties
  ////////////////////////////////////////
  ok_single_cycle: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok stayed high for more than one cycle");

  bus_exclusive: assert property (@(posedge clk) disable iff (rst) !(sen && wen))
    else $error("sen and wen high together");

  idle_quiet: assert property (@(posedge clk) disable iff (rst)
    state == dcache_port_pkg::st_idle |-> !ok && !miss)
    else $error("ok or miss high in idle");

  // Write-back only leaves on the last word
  wb_exit: assert property (@(posedge clk) disable iff (rst)
    state == dcache_port_pkg::st_writeback && !burst_done
      |=> state == dcache_port_pkg::st_writeback)
    else $error("write-back state left before burst_done");

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req,
  input  dcache_port_pkg::cpu_req_t cpu_in,
  output logic [31:0]               rdata,
  output logic                      ok,
  output logic                      miss,
  output dcache_port_pkg::mem_rd_t  mem_rd,
  input  logic                      rdata_ok,
  input  logic [31:0]               sdata,
  output dcache_port_pkg::mem_wr_t  mem_wr,
  input  logic                      wdata_ok
);

  dcache_port_pkg::cpu_req_t    req_q;
  dcache_port_pkg::ctrl_state_t state;
  logic                         hit, victim_dirty, burst_done, burst_accept, fill_write;
  logic                         set_valid, set_dirty, clr_dirty, touch, cpu_write;
  logic                         burst_start, burst_mode, sen, wen;
  logic [3:0]                   valid_vec;
  logic [31:0]                  evict_data;
  dcache_geom_pkg::way_t        hit_way, victim_way, way;
  dcache_geom_pkg::tag_t        victim_tag;
  dcache_geom_pkg::word_t       word_idx;

  assign way        = hit ? hit_way : victim_way;
  assign fill_write = burst_accept && (state == dcache_port_pkg::st_refill);

  ////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////
  assign mem_rd.sen   = sen;
  assign mem_rd.raddr = {req_q.addr.tag, req_q.addr.index, req_q.addr.word, 2'b00};
  assign mem_wr.wen   = wen;
  assign mem_wr.waddr = {victim_tag, req_q.addr.index, 6'b0};   // Line base
  assign mem_wr.wdata = evict_data;

  dcache_ctrl i_dcache_ctrl (.clk, .rst, .req, .cpu_in, .hit, .victim_dirty, .burst_done,
    .req_q, .state, .ok, .miss, .set_valid, .set_dirty, .clr_dirty, .touch, .cpu_write,
    .burst_start, .burst_mode);

  dcache_tag_array i_dcache_tag_array (.clk, .rst, .index(req_q.addr.index),
    .tag(req_q.addr.tag), .fill_way(way), .set_valid, .set_dirty, .clr_dirty, .hit,
    .hit_way, .valid_vec, .victim_dirty, .victim_tag);

  dcache_lru i_dcache_lru (.clk, .rst, .index(req_q.addr.index), .touch, .used_way(way),
    .valid_vec, .victim_way);

  dcache_data_array i_dcache_data_array (.clk, .index(req_q.addr.index), .way, .cpu_write,
    .word(req_q.addr.word), .wbyte(req_q.wbyte), .wdata(req_q.wdata), .fill_write,
    .fill_word(word_idx), .fill_data(sdata), .rd_word(word_idx), .rdata, .evict_data);

  dcache_burst_seq i_dcache_burst_seq (.clk, .rst, .start(burst_start), .mode(burst_mode),
    .first_word(req_q.addr.word), .rdata_ok, .wdata_ok, .word_idx, .sen, .wen,
    .accept(burst_accept), .done(burst_done));

endmodule

/* logic/dcache_burst_seq.sv */
`timescale 1ns/1ns

module dcache_burst_seq (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   mode,
  input  dcache_geom_pkg::word_t first_word,
  input  logic                   rdata_ok,
  input  logic                   wdata_ok,
  output dcache_geom_pkg::word_t word_idx,
  output logic                   sen,
  output logic                   wen,
  output logic                   accept,
  output logic                   done
);

  logic                   active;
  logic                   refill_q;   // Latched mode, 1 for refill
  dcache_geom_pkg::word_t count;

  assign sen    = active & refill_q;
  assign wen    = active & ~refill_q;
  assign accept = active & (refill_q ? rdata_ok : wdata_ok);
  assign done   = accept && (count == dcache_geom_pkg::word_t'(dcache_geom_pkg::line_words - 1));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active   <= 1'b0;
      refill_q <= 1'b0;
      count    <= '0;
      word_idx <= '0;
    end
    else if (start)
    begin
      active   <= 1'b1;
      refill_q <= mode;
      count    <= '0;
      word_idx <= mode ? first_word : '0;   // Refill begins at the requested word
    end
    else if (accept)
    begin
      count    <= count + 1'b1;
      word_idx <= word_idx + 1'b1;          // Wraps modulo 16
      if (done)
        active <= 1'b0;
    end
  end

endmodule

/* logic/dcache_data_array.sv */
`timescale 1ns/1ns

module dcache_data_array (
  input  logic                    clk,
  input  dcache_geom_pkg::index_t index,
  input  dcache_geom_pkg::way_t   way,
  input  logic                    cpu_write,
  input  dcache_geom_pkg::word_t  word,
  input  logic [3:0]              wbyte,
  input  logic [31:0]             wdata,
  input  logic                    fill_write,
  input  dcache_geom_pkg::word_t  fill_word,
  input  logic [31:0]             fill_data,
  input  dcache_geom_pkg::word_t  rd_word,
  output logic [31:0]             rdata,
  output logic [31:0]             evict_data
);

  logic [31:0] line_mem [dcache_geom_pkg::num_sets][dcache_geom_pkg::num_ways]
                        [dcache_geom_pkg::line_words];

  ////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (fill_write)
      line_mem[index][way][fill_word] <= fill_data;
    if (cpu_write)
    begin
      for (int b = 0; b < 4; b++)
        if (wbyte[b])
          line_mem[index][way][word][8*b +: 8] <= wdata[8*b +: 8];
    end
  end

  // CPU word and write-back word
  assign rdata      = line_mem[index][way][word];
  assign evict_data = line_mem[index][way][rd_word];

endmodule

/* logic/dcache_lru.sv */
`timescale 1ns/1ns

module dcache_lru (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_geom_pkg::index_t index,
  input  logic                    touch,
  input  dcache_geom_pkg::way_t   used_way,
  input  logic [3:0]              valid_vec,
  output dcache_geom_pkg::way_t   victim_way
);

  logic [dcache_geom_pkg::age_bits-1:0] age [dcache_geom_pkg::num_sets][dcache_geom_pkg::num_ways];
  logic [dcache_geom_pkg::age_bits-1:0] used_age;
  logic                                 found;

  assign used_age = age[index][used_way];

  // Used way to zero, younger or equal ways age by one
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < dcache_geom_pkg::num_sets; s++)
        for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
          age[s][w] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
        if (dcache_geom_pkg::way_t'(w) == used_way)
          age[index][w] <= '0;
        else if (age[index][w] <= used_age)
          age[index][w] <= age[index][w] + 1'b1;
    end
  end

  always_comb
  begin
    victim_way = '0;
    found      = 1'b0;
    for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
      if (!valid_vec[w] && !found)
      begin
        victim_way = dcache_geom_pkg::way_t'(w);
        found      = 1'b1;
      end
    if (!found)
      for (int w = 1; w < dcache_geom_pkg::num_ways; w++)
        if (age[index][w] > age[index][victim_way])   // Strict, lowest way wins ties
          victim_way = dcache_geom_pkg::way_t'(w);
  end

endmodule

/* logic/dcache_tag_array.sv */
`timescale 1ns/1ns

module dcache_tag_array (
  input  logic                    clk,
  input  logic                    rst,
  input  dcache_geom_pkg::index_t index,
  input  dcache_geom_pkg::tag_t   tag,
  input  dcache_geom_pkg::way_t   fill_way,
  input  logic                    set_valid,
  input  logic                    set_dirty,
  input  logic                    clr_dirty,
  output logic                    hit,
  output dcache_geom_pkg::way_t   hit_way,
  output logic [3:0]              valid_vec,
  output logic                    victim_dirty,
  output dcache_geom_pkg::tag_t   victim_tag
);

  dcache_geom_pkg::tag_t tags [dcache_geom_pkg::num_sets][dcache_geom_pkg::num_ways];
  logic [dcache_geom_pkg::num_ways-1:0] valid [dcache_geom_pkg::num_sets];
  logic [dcache_geom_pkg::num_ways-1:0] dirty [dcache_geom_pkg::num_sets];
  logic [dcache_geom_pkg::num_ways-1:0] match;

  // All four ways compared at once
  always_comb
  begin
    for (int w = 0; w < dcache_geom_pkg::num_ways; w++)
      match[w] = valid[index][w] && (tags[index][w] == tag);
  end

  always_comb
  begin
    hit_way = '0;
    for (int w = dcache_geom_pkg::num_ways - 1; w >= 0; w--)
      if (match[w])
        hit_way = dcache_geom_pkg::way_t'(w);
  end

  assign hit          = |match;
  assign valid_vec    = valid[index];
  assign victim_dirty = dirty[index][fill_way];
  assign victim_tag   = tags[index][fill_way];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < dcache_geom_pkg::num_sets; s++)
      begin
        valid[s] <= '0;
        dirty[s] <= '0;
      end
    end
    else
    begin
      if (set_valid)
        valid[index][fill_way] <= 1'b1;
      if (clr_dirty)
        dirty[index][fill_way] <= 1'b0;
      if (set_dirty)
        dirty[index][fill_way] <= 1'b1;   // Hit way on a hit, else the fill way
    end
  end

  always_ff @(posedge clk)
  begin
    if (set_valid)
      tags[index][fill_way] <= tag;   // Tag lands with the valid bit
  end

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         req,
  input  dcache_port_pkg::cpu_req_t    cpu_in,
  input  logic                         hit,
  input  logic                         victim_dirty,
  input  logic                         burst_done,
  output dcache_port_pkg::cpu_req_t    req_q,
  output dcache_port_pkg::ctrl_state_t state,
  output logic                         ok,
  output logic                         miss,
  output logic                         set_valid,
  output logic                         set_dirty,
  output logic                         clr_dirty,
  output logic                         touch,
  output logic                         cpu_write,
  output logic                         burst_start,
  output logic                         burst_mode
);

  dcache_port_pkg::ctrl_state_t next_state;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= dcache_port_pkg::st_idle;
    else
      state <= next_state;
  end

  // Request copy, taken once at acceptance
  always_ff @(posedge clk)
  begin
    if (state == dcache_port_pkg::st_idle && req)
      req_q <= cpu_in;
  end

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////
  always_comb
  begin
    next_state  = state;
    ok          = 1'b0;
    miss        = 1'b0;
    set_valid   = 1'b0;
    set_dirty   = 1'b0;
    clr_dirty   = 1'b0;
    touch       = 1'b0;
    cpu_write   = 1'b0;
    burst_start = 1'b0;
    burst_mode  = 1'b0;   // 1 selects refill, 0 write-back
    case (state)
      dcache_port_pkg::st_idle:
        if (req)
          next_state = dcache_port_pkg::st_lookup;
      dcache_port_pkg::st_lookup:
        if (hit)
        begin
          ok         = 1'b1;
          touch      = 1'b1;
          cpu_write  = req_q.we;
          set_dirty  = req_q.we;
          next_state = dcache_port_pkg::st_idle;
        end
        else
        begin
          miss        = 1'b1;
          burst_start = 1'b1;
          burst_mode  = ~victim_dirty;   // Clean victim goes straight to refill
          next_state  = victim_dirty ? dcache_port_pkg::st_writeback
                                     : dcache_port_pkg::st_refill;
        end
      dcache_port_pkg::st_writeback:
      begin
        miss = 1'b1;
        if (burst_done)
        begin
          burst_start = 1'b1;
          burst_mode  = 1'b1;
          next_state  = dcache_port_pkg::st_refill;
        end
      end
      dcache_port_pkg::st_refill:
      begin
        miss = 1'b1;
        if (burst_done)
        begin
          set_valid  = 1'b1;
          set_dirty  = req_q.we;    // Write miss leaves line dirty
          clr_dirty  = ~req_q.we;
          next_state = dcache_port_pkg::st_respond;
        end
      end
      dcache_port_pkg::st_respond:
      begin
        miss       = 1'b1;
        ok         = 1'b1;
        touch      = 1'b1;
        cpu_write  = req_q.we;
        next_state = dcache_port_pkg::st_idle;
      end
      default:
        next_state = dcache_port_pkg::st_idle;
    endcase
  end

endmodule

/* logic/dcache_port_pkg.sv */
package dcache_port_pkg;

  // CPU side request, held by the CPU until ok
  typedef struct packed {
    dcache_geom_pkg::addr_t addr;
    logic [31:0]            wdata;
    logic [3:0]             wbyte;
    logic                   we;
  } cpu_req_t;

  // Memory read channel
  typedef struct packed {
    logic        sen;
    logic [31:0] raddr;
  } mem_rd_t;

  // Memory write channel
  typedef struct packed {
    logic        wen;
    logic [31:0] waddr;
    logic [31:0] wdata;
  } mem_wr_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_refill,
    st_respond
  } ctrl_state_t;

endpackage

/* logic/dcache_geom_pkg.sv */
package dcache_geom_pkg;

  ////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////
  localparam int num_ways   = 4;
  localparam int num_sets   = 16;
  localparam int line_words = 16;
  localparam int tag_bits   = 22;
  localparam int index_bits = 4;
  localparam int word_bits  = 4;
  localparam int way_bits   = 2;
  localparam int age_bits   = 2;

  typedef logic [way_bits-1:0]   way_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [word_bits-1:0]  word_t;
  typedef logic [tag_bits-1:0]   tag_t;

  // Byte address split, MSB first
  typedef struct packed {
    tag_t       tag;
    index_t     index;
    word_t      word;
    logic [1:0] byte_off;
  } addr_t;

endpackage
